// ==== common/isaPkg.sv ====
package isaPkg;

	// instruction field sizes
	localparam int opWidth      = 6;
	localparam int functWidth   = 6;
	localparam int regAddrWidth = 5;
	localparam int xlen         = 32;

	// primary opcodes
	localparam logic [opWidth-1:0] opRtype  = 6'b000000;
	localparam logic [opWidth-1:0] opRegimm = 6'b000001;
	localparam logic [opWidth-1:0] opJ      = 6'b000010;
	localparam logic [opWidth-1:0] opJal    = 6'b000011;
	localparam logic [opWidth-1:0] opBeq    = 6'b000100;
	localparam logic [opWidth-1:0] opBne    = 6'b000101;
	localparam logic [opWidth-1:0] opBlez   = 6'b000110;
	localparam logic [opWidth-1:0] opBgtz   = 6'b000111;
	localparam logic [opWidth-1:0] opAddiu  = 6'b001001;
	localparam logic [opWidth-1:0] opSlti   = 6'b001010;
	localparam logic [opWidth-1:0] opSltiu  = 6'b001011;
	localparam logic [opWidth-1:0] opAndi   = 6'b001100;
	localparam logic [opWidth-1:0] opOri    = 6'b001101;
	localparam logic [opWidth-1:0] opXori   = 6'b001110;
	localparam logic [opWidth-1:0] opLui    = 6'b001111;
	localparam logic [opWidth-1:0] opLb     = 6'b100000;
	localparam logic [opWidth-1:0] opLh     = 6'b100001;
	localparam logic [opWidth-1:0] opLw     = 6'b100011;
	localparam logic [opWidth-1:0] opLbu    = 6'b100100;
	localparam logic [opWidth-1:0] opLhu    = 6'b100101;
	localparam logic [opWidth-1:0] opSb     = 6'b101000;
	localparam logic [opWidth-1:0] opSh     = 6'b101001;
	localparam logic [opWidth-1:0] opSw     = 6'b101011;

	// R-type function codes
	localparam logic [functWidth-1:0] fnSll  = 6'b000000;
	localparam logic [functWidth-1:0] fnSrl  = 6'b000010;
	localparam logic [functWidth-1:0] fnSra  = 6'b000011;
	localparam logic [functWidth-1:0] fnSllv = 6'b000100;
	localparam logic [functWidth-1:0] fnSrlv = 6'b000110;
	localparam logic [functWidth-1:0] fnSrav = 6'b000111;
	localparam logic [functWidth-1:0] fnJr   = 6'b001000;
	localparam logic [functWidth-1:0] fnJalr = 6'b001001;
	localparam logic [functWidth-1:0] fnAddu = 6'b100001;
	localparam logic [functWidth-1:0] fnSubu = 6'b100011;
	localparam logic [functWidth-1:0] fnAnd  = 6'b100100;
	localparam logic [functWidth-1:0] fnOr   = 6'b100101;
	localparam logic [functWidth-1:0] fnXor  = 6'b100110;
	localparam logic [functWidth-1:0] fnNor  = 6'b100111;
	localparam logic [functWidth-1:0] fnSlt  = 6'b101010;
	localparam logic [functWidth-1:0] fnSltu = 6'b101011;

	// low rt bit under REGIMM picks the branch
	localparam logic rtBltz = 1'b0;
	localparam logic rtBgez = 1'b1;

endpackage

// ==== common/ctrlPkg.sv ====
package ctrlPkg;

	localparam int aluOpWidth = 4;

	// ALU operation codes
	localparam logic [aluOpWidth-1:0] aluAdd  = 4'd0;
	localparam logic [aluOpWidth-1:0] aluSub  = 4'd1;
	localparam logic [aluOpWidth-1:0] aluAnd  = 4'd2;
	localparam logic [aluOpWidth-1:0] aluOr   = 4'd3;
	localparam logic [aluOpWidth-1:0] aluXor  = 4'd4;
	localparam logic [aluOpWidth-1:0] aluNor  = 4'd5;
	localparam logic [aluOpWidth-1:0] aluSlt  = 4'd6;
	localparam logic [aluOpWidth-1:0] aluSltu = 4'd7;
	localparam logic [aluOpWidth-1:0] aluSll  = 4'd8;
	localparam logic [aluOpWidth-1:0] aluSrl  = 4'd9;
	localparam logic [aluOpWidth-1:0] aluSra  = 4'd10;
	localparam logic [aluOpWidth-1:0] aluLui  = 4'd11;
	// no meaningful operation
	localparam logic [aluOpWidth-1:0] aluXxx  = 4'd15;

	// partitions decoded on address bits 31..28
	// data memory is 0xx1
	localparam logic [3:0] dataPartMask   = 4'b1001;
	localparam logic [3:0] dataPartMatch  = 4'b0001;
	// instruction memory is 0x1x
	localparam logic [3:0] instrPartMask  = 4'b1010;
	localparam logic [3:0] instrPartMatch = 4'b0010;

	// memory-mapped UART registers
	localparam logic [31:0] uartCtrlAddr = 32'h80000000;
	localparam logic [31:0] uartRxAddr   = 32'h80000004;
	localparam logic [31:0] uartTxAddr   = 32'h80000008;

endpackage

// ==== hdl/aluDecoder.sv ====
`timescale 1ns/1ps

module aluDecoder (
	input  logic [isaPkg::opWidth-1:0]     opcode,
	input  logic [isaPkg::functWidth-1:0]  funct,
	output logic [ctrlPkg::aluOpWidth-1:0] aluOp
);
	import isaPkg::*;
	import ctrlPkg::*;

	always_comb begin
		case (opcode)
			opRtype: begin
				case (funct)
					fnAddu, fnJr, fnJalr: aluOp = aluAdd;
					fnSubu:               aluOp = aluSub;
					fnAnd:                aluOp = aluAnd;
					fnOr:                 aluOp = aluOr;
					fnXor:                aluOp = aluXor;
					fnNor:                aluOp = aluNor;
					fnSlt:                aluOp = aluSlt;
					fnSltu:               aluOp = aluSltu;
					// variable shifts share the shift codes
					fnSll, fnSllv:        aluOp = aluSll;
					fnSrl, fnSrlv:        aluOp = aluSrl;
					fnSra, fnSrav:        aluOp = aluSra;
					default:              aluOp = aluXxx;
				endcase
			end
			opAddiu: aluOp = aluAdd;
			opSlti:  aluOp = aluSlt;
			opSltiu: aluOp = aluSltu;
			opAndi:  aluOp = aluAnd;
			opOri:   aluOp = aluOr;
			opXori:  aluOp = aluXor;
			opLui:   aluOp = aluLui;
			// address generation
			opLb, opLh, opLw, opLbu, opLhu,
			opSb, opSh, opSw: aluOp = aluAdd;
			default: aluOp = aluXxx;
		endcase
	end

endmodule

// ==== hdl/writeEnableGen.sv ====
`timescale 1ns/1ps

module writeEnableGen #(
	parameter logic [3:0] partMask  = ctrlPkg::dataPartMask,
	parameter logic [3:0] partMatch = ctrlPkg::dataPartMatch
) (
	input  logic [isaPkg::opWidth-1:0] opcode,
	input  logic [1:0]                 byteOffset,
	input  logic [isaPkg::xlen-1:0]    addr,
	output logic [3:0]                 writeEn
);
	import isaPkg::*;

	logic inPartition;

	// top nibble selects the memory
	assign inPartition = ((addr[xlen-1:xlen-4] & partMask) == partMatch);

	always_comb begin
		writeEn = 4'b0000;
		if (inPartition) begin
			case (opcode)
				opSb: writeEn = 4'b0001 << byteOffset;
				// halfword lands on the low or high half
				opSh: writeEn = byteOffset[1] ? 4'b1100 : 4'b0011;
				opSw: writeEn = 4'b1111;
				default: writeEn = 4'b0000;
			endcase
		end
	end

endmodule

// ==== hdl/branchCompare.sv ====
`timescale 1ns/1ps

module branchCompare (
	input  logic [isaPkg::opWidth-1:0] opcode,
	input  logic                       rtBit,
	input  logic [isaPkg::xlen-1:0]    rd1,
	input  logic [isaPkg::xlen-1:0]    rd2,
	output logic                       branchCtr
);
	import isaPkg::*;

	logic signed [xlen-1:0] rd1Signed;

	assign rd1Signed = $signed(rd1);

	always_comb begin
		case (opcode)
			opBeq:  branchCtr = (rd1 == rd2);
			opBne:  branchCtr = (rd1 != rd2);
			opBlez: branchCtr = (rd1Signed <= 0);
			opBgtz: branchCtr = (rd1Signed > 0);
			// bltz or bgez by the low rt bit
			opRegimm: branchCtr = (rtBit == rtBgez) ? (rd1Signed >= 0) : (rd1Signed < 0);
			default: branchCtr = 1'b0;
		endcase
	end

endmodule

// ==== hdl/forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit (
	input  logic [isaPkg::regAddrWidth-1:0] rsF,
	input  logic [isaPkg::regAddrWidth-1:0] rtF,
	input  logic [isaPkg::regAddrWidth-1:0] rsE,
	input  logic [isaPkg::regAddrWidth-1:0] rtE,
	input  logic [isaPkg::regAddrWidth-1:0] waM,
	input  logic                            regWriteM,
	output logic                            fwdAfromMtoE,
	output logic                            fwdBfromMtoE,
	output logic                            fwdAfromMtoF,
	output logic                            fwdBfromMtoF
);

	logic memWrites;

	// register zero is never forwarded
	assign memWrites = regWriteM && (waM != '0);

	assign fwdAfromMtoE = memWrites && (waM == rsE);
	assign fwdBfromMtoE = memWrites && (waM == rtE);
	assign fwdAfromMtoF = memWrites && (waM == rsF);
	assign fwdBfromMtoF = memWrites && (waM == rtF);

endmodule

// ==== hdl/uartAccess.sv ====
`timescale 1ns/1ps

module uartAccess (
	input  logic [isaPkg::opWidth-1:0] opcode,
	input  logic [isaPkg::xlen-1:0]    addr,
	input  logic                       dataInReady,
	input  logic                       dataOutValid,
	input  logic [7:0]                 uartDataOut,
	output logic                       uartCtr,
	output logic [isaPkg::xlen-1:0]    uartCtrOut,
	output logic                       dataInValid,
	output logic                       dataOutReady
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic isLoadWord;
	logic isStoreWord;
	logic ctrlHit;
	logic rxHit;

	assign isLoadWord  = (opcode == opLw);
	assign isStoreWord = (opcode == opSw);
	assign ctrlHit     = isLoadWord && (addr == uartCtrlAddr);
	assign rxHit       = isLoadWord && (addr == uartRxAddr);

	// load result comes from the UART, not data memory
	assign uartCtr = ctrlHit || rxHit;

	// receive byte consumed on read
	assign dataOutReady = rxHit;
	assign dataInValid  = isStoreWord && (addr == uartTxAddr);

	always_comb begin
		uartCtrOut = '0;
		if (ctrlHit) begin
			uartCtrOut = {{(xlen-2){1'b0}}, dataOutValid, dataInReady};
		end else if (rxHit) begin
			uartCtrOut = {{(xlen-8){1'b0}}, uartDataOut};
		end
	end

endmodule

// ==== control/mainDecoder.sv ====
`timescale 1ns/1ps

module mainDecoder (
	input  logic                            clk,
	input  logic                            rstN,
	input  logic [isaPkg::opWidth-1:0]      opcodeF,
	input  logic [isaPkg::functWidth-1:0]   functF,
	input  logic [isaPkg::regAddrWidth-1:0] rtF,
	output logic                            memToReg,
	output logic                            regWrite,
	output logic                            extType,
	output logic                            aluSrc,
	output logic                            regDst,
	output logic                            jump,
	output logic                            jr,
	output logic                            jal,
	output logic                            jalr,
	output logic [isaPkg::opWidth-1:0]      opcodeE,
	output logic [isaPkg::functWidth-1:0]   functE,
	output logic                            rtBitE
);
	import isaPkg::*;

	// fetch stage control table
	always_comb begin
		memToReg = 1'b0;
		regWrite = 1'b0;
		extType  = 1'b0;
		aluSrc   = 1'b0;
		regDst   = 1'b0;
		jump     = 1'b0;
		jr       = 1'b0;
		jal      = 1'b0;
		jalr     = 1'b0;
		case (opcodeF)
			opRtype: begin
				regDst   = 1'b1;
				// jr writes no register
				regWrite = (functF != fnJr);
				jr       = (functF == fnJr);
				jalr     = (functF == fnJalr);
			end
			opLb, opLh, opLw, opLbu, opLhu: begin
				memToReg = 1'b1;
				aluSrc   = 1'b1;
				regWrite = 1'b1;
			end
			opSb, opSh, opSw: begin
				memToReg = 1'b1;
				aluSrc   = 1'b1;
			end
			opAddiu, opSlti, opSltiu, opLui: begin
				aluSrc   = 1'b1;
				regWrite = 1'b1;
			end
			opAndi, opOri, opXori: begin
				// logic immediates are zero-extended
				extType  = 1'b1;
				aluSrc   = 1'b1;
				regWrite = 1'b1;
			end
			opJ: begin
				jump = 1'b1;
			end
			opJal: begin
				jump     = 1'b1;
				jal      = 1'b1;
				regDst   = 1'b1;
				regWrite = 1'b1;
			end
			// branches and unknown opcodes leave everything low
			default: begin
			end
		endcase
	end

	// fetch to execute field register that resets to sll
	always_ff @(posedge clk) begin
		if (!rstN) begin
			opcodeE <= '0;
			functE  <= '0;
			rtBitE  <= 1'b0;
		end else begin
			opcodeE <= opcodeF;
			functE  <= functF;
			rtBitE  <= rtF[0];
		end
	end

endmodule

// ==== control/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
	input  logic                              clk,
	input  logic                              rstN,
	// fetch stage fields
	input  logic [isaPkg::opWidth-1:0]        opcodeF,
	input  logic [isaPkg::functWidth-1:0]     functF,
	input  logic [isaPkg::regAddrWidth-1:0]   rsF,
	input  logic [isaPkg::regAddrWidth-1:0]   rtF,
	// execute and memory stage registers
	input  logic [isaPkg::regAddrWidth-1:0]   rsE,
	input  logic [isaPkg::regAddrWidth-1:0]   rtE,
	input  logic [isaPkg::regAddrWidth-1:0]   waM,
	input  logic                              regWriteM,
	input  logic [1:0]                        byteOffsetE,
	input  logic [isaPkg::xlen-1:0]           aluOutE,
	input  logic [isaPkg::xlen-1:0]           rd1Fwd,
	input  logic [isaPkg::xlen-1:0]           rd2Fwd,
	// UART status and data
	input  logic                              dataInReady,
	input  logic                              dataOutValid,
	input  logic [7:0]                        uartDataOut,
	// fetch controls
	output logic                              memToReg,
	output logic                              regWrite,
	output logic                              extType,
	output logic                              aluSrc,
	output logic                              regDst,
	output logic                              jump,
	output logic                              jr,
	output logic                              jal,
	output logic                              jalr,
	// execute controls
	output logic [ctrlPkg::aluOpWidth-1:0]    aluOp,
	output logic [3:0]                        dataMemWriteEn,
	output logic [3:0]                        instrMemWriteEn,
	output logic                              branchCtr,
	// forwarding
	output logic                              fwdAfromMtoE,
	output logic                              fwdBfromMtoE,
	output logic                              fwdAfromMtoF,
	output logic                              fwdBfromMtoF,
	// UART access
	output logic                              uartCtr,
	output logic [isaPkg::xlen-1:0]           uartCtrOut,
	output logic                              dataInValid,
	output logic                              dataOutReady
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic [opWidth-1:0]    opcodeE;
	logic [functWidth-1:0] functE;
	logic                  rtBitE;

	mainDecoder mainDecoder_inst (
		.clk      (clk),
		.rstN     (rstN),
		.opcodeF  (opcodeF),
		.functF   (functF),
		.rtF      (rtF),
		.memToReg (memToReg),
		.regWrite (regWrite),
		.extType  (extType),
		.aluSrc   (aluSrc),
		.regDst   (regDst),
		.jump     (jump),
		.jr       (jr),
		.jal      (jal),
		.jalr     (jalr),
		.opcodeE  (opcodeE),
		.functE   (functE),
		.rtBitE   (rtBitE)
	);

	aluDecoder aluDecoder_inst (
		.opcode (opcodeE),
		.funct  (functE),
		.aluOp  (aluOp)
	);

	writeEnableGen #(
		.partMask  (dataPartMask),
		.partMatch (dataPartMatch)
	) dataWriteEn_inst (
		.opcode     (opcodeE),
		.byteOffset (byteOffsetE),
		.addr       (aluOutE),
		.writeEn    (dataMemWriteEn)
	);

	writeEnableGen #(
		.partMask  (instrPartMask),
		.partMatch (instrPartMatch)
	) instrWriteEn_inst (
		.opcode     (opcodeE),
		.byteOffset (byteOffsetE),
		.addr       (aluOutE),
		.writeEn    (instrMemWriteEn)
	);

	branchCompare branchCompare_inst (
		.opcode    (opcodeE),
		.rtBit     (rtBitE),
		.rd1       (rd1Fwd),
		.rd2       (rd2Fwd),
		.branchCtr (branchCtr)
	);

	forwardUnit forwardUnit_inst (
		.rsF          (rsF),
		.rtF          (rtF),
		.rsE          (rsE),
		.rtE          (rtE),
		.waM          (waM),
		.regWriteM    (regWriteM),
		.fwdAfromMtoE (fwdAfromMtoE),
		.fwdBfromMtoE (fwdBfromMtoE),
		.fwdAfromMtoF (fwdAfromMtoF),
		.fwdBfromMtoF (fwdBfromMtoF)
	);

	uartAccess uartAccess_inst (
		.opcode       (opcodeE),
		.addr         (aluOutE),
		.dataInReady  (dataInReady),
		.dataOutValid (dataOutValid),
		.uartDataOut  (uartDataOut),
		.uartCtr      (uartCtr),
		.uartCtrOut   (uartCtrOut),
		.dataInValid  (dataInValid),
		.dataOutReady (dataOutReady)
	);

endmodule

// ==== bench/tbVectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// each row gives name, opcode, funct, rt, byte offset and ALU address, then operand codes
// {rd1, rd2}, fetch controls in port order from memToReg to jalr, aluOp, {data, instr}
// write enables, {uartCtr, dataInValid, dataOutReady} and uartCtrOut
// operand code 0 is lfsr, 1 zero, 2 all ones, 3 most negative
task automatic loadVectors();
	addRow("addu", opRtype, fnAddu, 5'd1, '0, '0, '0, 9'h090, aluAdd, '0, '0, '0);
	addRow("subu", opRtype, fnSubu, 5'd2, '0, '0, '0, 9'h090, aluSub, '0, '0, '0);
	addRow("sltu", opRtype, fnSltu, 5'd3, '0, '0, '0, 9'h090, aluSltu, '0, '0, '0);
	addRow("srav", opRtype, fnSrav, 5'd1, '0, '0, '0, 9'h090, aluSra, '0, '0, '0);
	addRow("jr", opRtype, fnJr, '0, '0, '0, '0, 9'h014, aluAdd, '0, '0, '0);
	addRow("jalr", opRtype, fnJalr, 5'd2, '0, '0, '0, 9'h091, aluAdd, '0, '0, '0);
	addRow("addiu", opAddiu, fnSll, 5'd1, '0, '0, '0, 9'h0a0, aluAdd, '0, '0, '0);
	addRow("andi", opAndi, fnSll, 5'd2, '0, '0, '0, 9'h0e0, aluAnd, '0, '0, '0);
	addRow("lui", opLui, fnSll, 5'd3, '0, '0, '0, 9'h0a0, aluLui, '0, '0, '0);
	addRow("lwMem", opLw, fnSll, 5'd1, '0, 32'h10000040, '0, 9'h1a0, aluAdd, '0, '0, '0);
	// receive address but not a word load
	addRow("lbuRx", opLbu, fnSll, 5'd2, '0, 32'h80000004, '0, 9'h1a0, aluAdd, '0, '0, '0);
	addRow("j", opJ, fnSll, '0, '0, '0, '0, 9'h008, aluXxx, '0, '0, '0);
	addRow("jal", opJal, fnSll, 5'd3, '0, '0, '0, 9'h09a, aluXxx, '0, '0, '0);
	addRow("sb0", opSb, fnSll, '0, 2'd0, 32'h10000000, '0, 9'h120, aluAdd, 8'h10, '0, '0);
	addRow("sb1", opSb, fnSll, '0, 2'd1, 32'h50000001, '0, 9'h120, aluAdd, 8'h20, '0, '0);
	addRow("sb2", opSb, fnSll, '0, 2'd2, 32'h70000002, '0, 9'h120, aluAdd, 8'h44, '0, '0);
	addRow("sb3", opSb, fnSll, '0, 2'd3, 32'h20000003, '0, 9'h120, aluAdd, 8'h08, '0, '0);
	addRow("sh0", opSh, fnSll, '0, 2'd0, 32'h10000000, '0, 9'h120, aluAdd, 8'h30, '0, '0);
	addRow("sh1", opSh, fnSll, '0, 2'd1, 32'h20000001, '0, 9'h120, aluAdd, 8'h03, '0, '0);
	addRow("sh2", opSh, fnSll, '0, 2'd2, 32'h30000002, '0, 9'h120, aluAdd, 8'hcc, '0, '0);
	addRow("sh3", opSh, fnSll, '0, 2'd3, 32'h50000003, '0, 9'h120, aluAdd, 8'hc0, '0, '0);
	addRow("sw0", opSw, fnSll, '0, 2'd0, 32'h10000000, '0, 9'h120, aluAdd, 8'hf0, '0, '0);
	addRow("sw1", opSw, fnSll, '0, 2'd1, 32'h60000001, '0, 9'h120, aluAdd, 8'h0f, '0, '0);
	addRow("sw2", opSw, fnSll, '0, 2'd2, 32'h30000002, '0, 9'h120, aluAdd, 8'hff, '0, '0);
	// top nibble 4 is outside both memories
	addRow("sw3", opSw, fnSll, '0, 2'd3, 32'h40000003, '0, 9'h120, aluAdd, '0, '0, '0);
	addRow("beqRnd", opBeq, fnSll, 5'd1, '0, '0, 4'h0, '0, aluXxx, '0, '0, '0);
	addRow("beqZero", opBeq, fnSll, 5'd2, '0, '0, 4'h5, '0, aluXxx, '0, '0, '0);
	addRow("bneRnd", opBne, fnSll, 5'd3, '0, '0, 4'h0, '0, aluXxx, '0, '0, '0);
	addRow("blezZero", opBlez, fnSll, '0, '0, '0, 4'h4, '0, aluXxx, '0, '0, '0);
	addRow("bgtzMin", opBgtz, fnSll, '0, '0, '0, 4'hc, '0, aluXxx, '0, '0, '0);
	addRow("bgtzRnd", opBgtz, fnSll, 5'd1, '0, '0, 4'h0, '0, aluXxx, '0, '0, '0);
	addRow("bltzOnes", opRegimm, fnSll, 5'd0, '0, '0, 4'h8, '0, aluXxx, '0, '0, '0);
	addRow("bgezRnd", opRegimm, fnSll, 5'd1, '0, '0, 4'h0, '0, aluXxx, '0, '0, '0);
	addRow("lwCtrl", opLw, fnSll, '0, '0, 32'h80000000, '0, 9'h1a0, aluAdd, '0, 3'h4, 32'h1);
	addRow("lwRx", opLw, fnSll, '0, '0, 32'h80000004, '0, 9'h1a0, aluAdd, '0, 3'h5, 32'hc3);
	addRow("swTx", opSw, fnSll, '0, '0, 32'h80000008, '0, 9'h120, aluAdd, '0, 3'h2, '0);
	addRow("badOp", 6'b111111, fnSll, '0, '0, '0, '0, '0, aluXxx, '0, '0, '0);
endtask

`endif

// ==== bench/tbControlUnit.sv ====
`timescale 1ns/1ps

module tbControlUnit;
	import isaPkg::*;
	import ctrlPkg::*;

	typedef struct packed {
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  rt;
		logic [1:0]  off;
		logic [31:0] addr;
		logic [3:0]  opnd;
		logic [8:0]  ctrl;
		logic [3:0]  alu;
		logic [7:0]  we;
		logic [2:0]  strobes;
		logic [31:0] uartOut;
	} vecT;

	logic clk, rstN, regWriteM, dataInReady, dataOutValid;
	logic [5:0] opcodeF, functF;
	logic [4:0] rsF, rtF, rsE, rtE, waM;
	logic [1:0] byteOffsetE;
	logic [31:0] aluOutE, rd1Fwd, rd2Fwd;
	logic [7:0] uartDataOut;
	logic memToReg, regWrite, extType, aluSrc, regDst, jump, jr, jal, jalr;
	logic [3:0] aluOp, dataMemWriteEn, instrMemWriteEn;
	logic branchCtr, fwdAfromMtoE, fwdBfromMtoE, fwdAfromMtoF, fwdBfromMtoF;
	logic uartCtr, dataInValid, dataOutReady;
	logic [31:0] uartCtrOut;

	vecT vectors[$];
	string names[$];
	logic [31:0] lfsrState;
	int errors;
	int checks;
	int cycles;
	int cycleLimit;

	controlUnit controlUnit_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout, the vector loop was still running after %0d cycles", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// Galois form with taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	task automatic takeBits(input int count, output logic [31:0] value);
		int k;
		value = '0;
		for (k = 0; k < count; k++) begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	function automatic logic [31:0] pickOperand(input logic [1:0] code, input logic [31:0] rnd);
		case (code)
			2'd1: return 32'h00000000;
			2'd2: return 32'hffffffff;
			2'd3: return 32'h80000000;
			default: return rnd;
		endcase
	endfunction

	// reference branch outcome from the sign bit and a zero test
	function automatic logic expectBranch(input logic [5:0] op, input logic rtLow,
			input logic [31:0] a, input logic [31:0] b);
		logic negative;
		logic zero;
		negative = a[31];
		zero = (a == 32'h0);
		case (op)
			opBeq: return a == b;
			opBne: return a != b;
			opBlez: return negative || zero;
			opBgtz: return !negative && !zero;
			opRegimm: return rtLow ? !negative : negative;
			default: return 1'b0;
		endcase
	endfunction

	task automatic addRow(input string name, input logic [5:0] op, input logic [5:0] fn,
			input logic [4:0] rt, input logic [1:0] off, input logic [31:0] addr,
			input logic [3:0] opnd, input logic [8:0] ctrl, input logic [3:0] alu,
			input logic [7:0] we, input logic [2:0] strobes, input logic [31:0] uartOut);
		vecT v;
		v = '{op, fn, rt, off, addr, opnd, ctrl, alu, we, strobes, uartOut};
		vectors.push_back(v);
		names.push_back(name);
	endtask

	`include "tbVectors.svh"

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("mismatch in %s, expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic driveOperands(input logic [3:0] codes);
		logic [31:0] bits;
		takeBits(32, bits);
		rd1Fwd = pickOperand(codes[3:2], bits);
		if (codes[1:0] != 2'd0) begin
			rd2Fwd = pickOperand(codes[1:0], 32'h0);
		end else begin
			// equal pairs about half the time
			takeBits(1, bits);
			if (bits[0]) begin
				rd2Fwd = rd1Fwd;
			end else begin
				takeBits(32, bits);
				rd2Fwd = bits;
			end
		end
	endtask

	// two-bit register numbers make matches and waM of zero common
	task automatic driveForward();
		logic [31:0] bits;
		takeBits(9, bits);
		rsF = {3'b000, bits[1:0]};
		rsE = {3'b000, bits[3:2]};
		rtE = {3'b000, bits[5:4]};
		waM = {3'b000, bits[7:6]};
		regWriteM = bits[8];
	endtask

	task automatic checkForward(input string name);
		logic live;
		live = regWriteM && (waM != 5'd0);
		checkValue({name, " fwdAE"}, 32'(live && waM == rsE), 32'(fwdAfromMtoE));
		checkValue({name, " fwdBE"}, 32'(live && waM == rtE), 32'(fwdBfromMtoE));
		checkValue({name, " fwdAF"}, 32'(live && waM == rsF), 32'(fwdAfromMtoF));
		checkValue({name, " fwdBF"}, 32'(live && waM == rtF), 32'(fwdBfromMtoF));
	endtask

	task automatic checkExec(input string name, input vecT v);
		logic taken;
		taken = expectBranch(v.op, v.rt[0], rd1Fwd, rd2Fwd);
		checkValue({name, " aluOp"}, 32'(v.alu), 32'(aluOp));
		checkValue({name, " dataWe"}, 32'(v.we[7:4]), 32'(dataMemWriteEn));
		checkValue({name, " instrWe"}, 32'(v.we[3:0]), 32'(instrMemWriteEn));
		checkValue({name, " branch"}, 32'(taken), 32'(branchCtr));
		checkValue({name, " uart"}, 32'(v.strobes), 32'({uartCtr, dataInValid, dataOutReady}));
		checkValue({name, " uartOut"}, v.uartOut, uartCtrOut);
	endtask

	initial begin
		int i;
		string rowName;
		errors = 0;
		checks = 0;
		lfsrState = 32'h1f51;
		rstN = 1'b0;
		// a word load of the receive register waits in fetch while reset holds execute
		opcodeF = opLw;
		functF = '0;
		rsF = '0;
		rtF = '0;
		rsE = '0;
		rtE = '0;
		waM = '0;
		regWriteM = 1'b0;
		byteOffsetE = '0;
		aluOutE = uartRxAddr;
		rd1Fwd = '0;
		rd2Fwd = '0;
		dataInReady = 1'b1;
		dataOutValid = 1'b0;
		uartDataOut = 8'hc3;
		loadVectors();
		cycleLimit = 16 + 2 * vectors.size() + 200;
		repeat (16) @(posedge clk);
		#1;
		rstN = 1'b1;
		for (i = 0; i <= vectors.size(); i++) begin
			rowName = "drain";
			opcodeF = opRtype;
			functF = fnSll;
			rtF = '0;
			if (i < vectors.size()) begin
				rowName = names[i];
				opcodeF = vectors[i].op;
				functF = vectors[i].fn;
				rtF = vectors[i].rt;
			end
			// execute inputs belong to the previous row
			if (i > 0) begin
				byteOffsetE = vectors[i-1].off;
				aluOutE = vectors[i-1].addr;
				driveOperands(vectors[i-1].opnd);
			end
			driveForward();
			@(negedge clk);
			if (i < vectors.size()) begin
				checkValue({rowName, " ctrl"}, 32'(vectors[i].ctrl),
					32'({memToReg, regWrite, extType, aluSrc, regDst, jump, jr, jal, jalr}));
			end
			if (i == 0) begin
				checkValue("reset dataWe", 32'h0, 32'(dataMemWriteEn));
				checkValue("reset instrWe", 32'h0, 32'(instrMemWriteEn));
				checkValue("reset branch", 32'h0, 32'(branchCtr));
				checkValue("reset uart", 32'h0, 32'({uartCtr, dataInValid, dataOutReady}));
			end else begin
				checkExec(names[i-1], vectors[i-1]);
			end
			checkForward(rowName);
			@(posedge clk);
			#1;
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+bench
common/isaPkg.sv
common/ctrlPkg.sv
hdl/aluDecoder.sv
hdl/writeEnableGen.sv
hdl/branchCompare.sv
hdl/forwardUnit.sv
hdl/uartAccess.sv
control/mainDecoder.sv
control/controlUnit.sv
bench/tbControlUnit.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -f tb.f --top-module tbControlUnit -o simv > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -qF "*** TEST PASSED ***" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
